//--- rtl/decode_pkg.sv
package decode_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int field_w    = 6;    // opcode and funct
    localparam int shamt_w    = 5;
    localparam int imm16_w    = 16;
    localparam int reg_count  = 32;

    // lsb of each instruction field
    localparam int opcode_lsb = 26;
    localparam int rs_lsb     = 21;
    localparam int rt_lsb     = 16;
    localparam int rd_lsb     = 11;
    localparam int shamt_lsb  = 6;
    localparam int funct_lsb  = 0;
    localparam int imm16_lsb  = 0;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [field_w-1:0]    opcode_t;
    typedef logic [field_w-1:0]    funct_t;

    localparam opcode_t op_special = 6'b000000;
    localparam opcode_t op_addi    = 6'b001000;
    localparam opcode_t op_addiu   = 6'b001001;
    localparam opcode_t op_slti    = 6'b001010;
    localparam opcode_t op_sltiu   = 6'b001011;
    localparam opcode_t op_andi    = 6'b001100;
    localparam opcode_t op_ori     = 6'b001101;
    localparam opcode_t op_xori    = 6'b001110;
    localparam opcode_t op_lui     = 6'b001111;

    localparam funct_t fn_sll  = 6'b000000;
    localparam funct_t fn_srl  = 6'b000010;
    localparam funct_t fn_sra  = 6'b000011;
    localparam funct_t fn_sllv = 6'b000100;
    localparam funct_t fn_srlv = 6'b000110;
    localparam funct_t fn_srav = 6'b000111;
    localparam funct_t fn_movz = 6'b001010;
    localparam funct_t fn_movn = 6'b001011;
    localparam funct_t fn_add  = 6'b100000;
    localparam funct_t fn_addu = 6'b100001;
    localparam funct_t fn_sub  = 6'b100010;
    localparam funct_t fn_subu = 6'b100011;
    localparam funct_t fn_and  = 6'b100100;
    localparam funct_t fn_or   = 6'b100101;
    localparam funct_t fn_xor  = 6'b100110;
    localparam funct_t fn_nor  = 6'b100111;
    localparam funct_t fn_slt  = 6'b101010;
    localparam funct_t fn_sltu = 6'b101011;

    typedef enum logic [7:0] {
        aluop_rst   = 8'b0000_0000,    // driven only while in reset
        aluop_srl   = 8'b0000_0010,
        aluop_sra   = 8'b0000_0011,
        aluop_movz  = 8'b0000_1010,
        aluop_movn  = 8'b0000_1011,
        aluop_add   = 8'b0010_0000,
        aluop_addu  = 8'b0010_0001,
        aluop_sub   = 8'b0010_0010,
        aluop_subu  = 8'b0010_0011,
        aluop_and   = 8'b0010_0100,
        aluop_or    = 8'b0010_0101,
        aluop_xor   = 8'b0010_0110,
        aluop_nor   = 8'b0010_0111,
        aluop_slt   = 8'b0010_1010,
        aluop_sltu  = 8'b0010_1011,
        aluop_addi  = 8'b0101_0101,
        aluop_addiu = 8'b0101_0110,
        aluop_slti  = 8'b0101_0111,
        aluop_sltiu = 8'b0101_1000,
        aluop_sll   = 8'b0111_1100
    } aluop_e;

    // nop is sll r0, r0, 0
    localparam aluop_e aluop_nop = aluop_sll;

    typedef enum logic [2:0] {
        alusel_none  = 3'b000,
        alusel_logic = 3'b001,
        alusel_shift = 3'b010,
        alusel_move  = 3'b011,
        alusel_arith = 3'b100
    } alusel_e;

    typedef enum logic [1:0] {
        imm_zext  = 2'd0,
        imm_sext  = 2'd1,
        imm_upper = 2'd2,
        imm_shamt = 2'd3
    } imm_kind_e;

endpackage

//--- rtl/inst_decoder.sv
module inst_decoder import decode_pkg::*; (
    input  logic      rst,
    input  word_t     inst_i,
    input  word_t     rt_value_i,     // forwarded rt operand
    output aluop_e    aluop_o,
    output alusel_e   alusel_o,
    output logic      wreg_o,
    output reg_addr_t wd_o,
    output logic      reg1_read_o,
    output reg_addr_t reg1_addr_o,
    output logic      reg2_read_o,
    output reg_addr_t reg2_addr_o,
    output imm_kind_e imm_kind_o
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic      wreg_raw;
    logic      wreg_nz;    // movn
    logic      wreg_z;     // movz
    logic      rt_nonzero;

    assign opcode = inst_i[opcode_lsb +: field_w];
    assign funct  = inst_i[funct_lsb +: field_w];
    assign rs     = inst_i[rs_lsb +: reg_addr_w];
    assign rt     = inst_i[rt_lsb +: reg_addr_w];
    assign rd     = inst_i[rd_lsb +: reg_addr_w];

    function automatic aluop_e special_aluop(funct_t fn);
        case (fn)
            fn_and:          return aluop_and;
            fn_or:           return aluop_or;
            fn_xor:          return aluop_xor;
            fn_nor:          return aluop_nor;
            fn_sll, fn_sllv: return aluop_sll;
            fn_srl, fn_srlv: return aluop_srl;
            fn_sra, fn_srav: return aluop_sra;
            fn_movn:         return aluop_movn;
            fn_movz:         return aluop_movz;
            fn_add:          return aluop_add;
            fn_addu:         return aluop_addu;
            fn_sub:          return aluop_sub;
            fn_subu:         return aluop_subu;
            fn_slt:          return aluop_slt;
            fn_sltu:         return aluop_sltu;
            default:         return aluop_nop;
        endcase
    endfunction

    function automatic aluop_e imm_aluop(opcode_t op);
        case (op)
            op_andi:         return aluop_and;
            op_ori, op_lui:  return aluop_or;    // lui is or with the upper half
            op_xori:         return aluop_xor;
            op_addi:         return aluop_addi;
            op_addiu:        return aluop_addiu;
            op_slti:         return aluop_slti;
            op_sltiu:        return aluop_sltiu;
            default:         return aluop_nop;
        endcase
    endfunction

    always_comb begin
        aluop_o     = aluop_nop;
        alusel_o    = alusel_none;
        wreg_raw    = 1'b0;
        wreg_nz     = 1'b0;
        wreg_z      = 1'b0;
        wd_o        = rd;
        reg1_read_o = 1'b0;
        reg1_addr_o = rs;
        reg2_read_o = 1'b0;
        reg2_addr_o = rt;
        imm_kind_o  = imm_zext;
        if (rst) begin
            aluop_o     = aluop_rst;
            wd_o        = '0;
            reg1_addr_o = '0;
            reg2_addr_o = '0;
        end else begin
            aluop_o = (opcode == op_special) ? special_aluop(funct) : imm_aluop(opcode);
            case (opcode)
                op_special: begin
                    case (funct)
                        fn_and, fn_or, fn_xor, fn_nor: begin
                            alusel_o    = alusel_logic;
                            wreg_raw    = 1'b1;
                            reg1_read_o = 1'b1;
                            reg2_read_o = 1'b1;
                        end
                        fn_sll, fn_srl, fn_sra: begin
                            alusel_o    = alusel_shift;
                            wreg_raw    = 1'b1;
                            reg2_read_o = 1'b1;
                            imm_kind_o  = imm_shamt;    // shamt lands in operand 1
                        end
                        fn_sllv, fn_srlv, fn_srav: begin
                            alusel_o    = alusel_shift;
                            wreg_raw    = 1'b1;
                            reg1_read_o = 1'b1;
                            reg2_read_o = 1'b1;
                        end
                        fn_movn, fn_movz: begin
                            alusel_o    = alusel_move;
                            wreg_nz     = (funct == fn_movn);
                            wreg_z      = (funct == fn_movz);
                            reg1_read_o = 1'b1;
                            reg2_read_o = 1'b1;
                        end
                        fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu: begin
                            alusel_o    = alusel_arith;
                            wreg_raw    = 1'b1;
                            reg1_read_o = 1'b1;
                            reg2_read_o = 1'b1;
                        end
                        default: begin
                        end
                    endcase
                end
                op_andi, op_ori, op_xori, op_lui: begin
                    alusel_o    = alusel_logic;
                    wreg_raw    = 1'b1;
                    wd_o        = rt;
                    reg1_read_o = 1'b1;    // lui reads r0 in legal code
                    imm_kind_o  = (opcode == op_lui) ? imm_upper : imm_zext;
                end
                op_addi, op_addiu, op_slti, op_sltiu: begin
                    alusel_o    = alusel_arith;
                    wreg_raw    = 1'b1;
                    wd_o        = rt;
                    reg1_read_o = 1'b1;
                    imm_kind_o  = imm_sext;
                end
                default: begin
                end
            endcase
        end
    end

    // conditional moves test the forwarded rt value
    assign rt_nonzero = |rt_value_i;
    assign wreg_o     = wreg_raw | (wreg_nz & rt_nonzero) | (wreg_z & ~rt_nonzero);

endmodule

//--- rtl/imm_gen.sv
module imm_gen import decode_pkg::*; (
    input  word_t     inst_i,
    input  imm_kind_e imm_kind_i,
    output word_t     imm_o
);

    logic [imm16_w-1:0] imm16;
    logic [shamt_w-1:0] shamt;

    assign imm16 = inst_i[imm16_lsb +: imm16_w];
    assign shamt = inst_i[shamt_lsb +: shamt_w];

    always_comb begin
        case (imm_kind_i)
            imm_zext: begin
                imm_o = {{(word_w - imm16_w){1'b0}}, imm16};
            end
            imm_sext: begin
                imm_o = {{(word_w - imm16_w){imm16[imm16_w-1]}}, imm16};    // full 32 bits
            end
            imm_upper: begin
                imm_o = {imm16, {(word_w - imm16_w){1'b0}}};
            end
            default: begin
                imm_o = {{(word_w - shamt_w){1'b0}}, shamt};
            end
        endcase
    end

endmodule

//--- rtl/operand_fwd.sv
module operand_fwd import decode_pkg::*; (
    input  logic      rst,
    input  logic      read_i,
    input  reg_addr_t addr_i,
    input  word_t     reg_data_i,
    input  word_t     imm_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    output word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // r0 gets no special treatment here
    assign ex_hit  = read_i && ex_wreg_i && (ex_wd_i == addr_i);
    assign mem_hit = read_i && mem_wreg_i && (mem_wd_i == addr_i);

    always_comb begin
        if (rst) begin
            operand_o = '0;
        end else if (ex_hit) begin
            operand_o = ex_wdata_i;    // youngest result wins
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else if (read_i) begin
            operand_o = reg_data_i;
        end else begin
            operand_o = imm_i;
        end
    end

endmodule

//--- rtl/reg_file.sv
module reg_file import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i
);

    word_t regs [reg_count];
    logic  wr_en;
    logic  byp1;
    logic  byp2;

    assign wr_en = we_i && (waddr_i != '0);    // r0 never written

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write shows up on the read ports
    assign byp1 = wr_en && (raddr1_i == waddr_i);
    assign byp2 = wr_en && (raddr2_i == waddr_i);

    assign rdata1_o = (raddr1_i == '0) ? '0 : (byp1 ? wdata_i : regs[raddr1_i]);
    assign rdata2_o = (raddr2_i == '0) ? '0 : (byp2 ? wdata_i : regs[raddr2_i]);

endmodule

//--- rtl/decode_stage.sv
module decode_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     inst_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_waddr_i,
    input  word_t     wb_wdata_i,
    output aluop_e    aluop_o,
    output alusel_e   alusel_o,
    output logic      wreg_o,
    output reg_addr_t wd_o,
    output word_t     reg1_o,
    output word_t     reg2_o
);

    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    imm_kind_e imm_kind;
    word_t     imm;
    word_t     rdata1;
    word_t     rdata2;

    inst_decoder u_decoder (
        .rst         (rst),
        .inst_i      (inst_i),
        .rt_value_i  (reg2_o),    // movn/movz condition
        .aluop_o     (aluop_o),
        .alusel_o    (alusel_o),
        .wreg_o      (wreg_o),
        .wd_o        (wd_o),
        .reg1_read_o (reg1_read),
        .reg1_addr_o (reg1_addr),
        .reg2_read_o (reg2_read),
        .reg2_addr_o (reg2_addr),
        .imm_kind_o  (imm_kind)
    );

    imm_gen u_imm (
        .inst_i     (inst_i),
        .imm_kind_i (imm_kind),
        .imm_o      (imm)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .raddr1_i (reg1_addr),
        .raddr2_i (reg2_addr),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (wb_we_i),
        .waddr_i  (wb_waddr_i),
        .wdata_i  (wb_wdata_i)
    );

    operand_fwd fwd_rs (
        .rst         (rst),
        .read_i      (reg1_read),
        .addr_i      (reg1_addr),
        .reg_data_i  (rdata1),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg1_o)
    );

    operand_fwd fwd_rt (
        .rst         (rst),
        .read_i      (reg2_read),
        .addr_i      (reg2_addr),
        .reg_data_i  (rdata2),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg2_o)
    );

endmodule

//--- testbench/decode_checker.sv
module decode_checker import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     inst_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_waddr_i,
    input  word_t     wb_wdata_i,
    input  aluop_e    aluop_o,
    input  alusel_e   alusel_o,
    input  logic      wreg_o,
    input  reg_addr_t wd_o,
    input  word_t     reg1_o,
    input  word_t     reg2_o,
    output int        decode_errors_o,
    output int        operand_errors_o,
    output int        checks_o
);

    word_t     shadow [reg_count];    // model of the register file
    logic [7:0] exp_aluop;
    logic [2:0] exp_alusel;
    logic      exp_wraw;
    logic      exp_movn;
    logic      exp_movz;
    logic      exp_wreg;
    reg_addr_t exp_wd;
    logic      exp_rd1;
    logic      exp_rd2;
    word_t     exp_imm;
    word_t     exp_op1;
    word_t     exp_op2;

    initial begin
        decode_errors_o  = 0;
        operand_errors_o = 0;
        checks_o         = 0;
        for (int i = 0; i < reg_count; i++) begin
            shadow[i] = '0;
        end
    end

    // decode rules straight from the ISA tables
    task automatic model_decode(input word_t inst);
        logic [5:0] op;
        logic [5:0] fn;
        op = inst[31:26];
        fn = inst[5:0];
        exp_aluop  = 8'h7c;    // nop
        exp_alusel = 3'd0;
        exp_wraw   = 1'b0;
        exp_movn   = 1'b0;
        exp_movz   = 1'b0;
        exp_wd     = inst[15:11];
        exp_rd1    = 1'b0;
        exp_rd2    = 1'b0;
        exp_imm    = {16'h0, inst[15:0]};
        if (op == 6'h00) begin
            case (fn)
                6'h24, 6'h25, 6'h26, 6'h27: begin
                    exp_aluop  = {2'b00, fn};
                    exp_alusel = 3'd1;
                end
                6'h20, 6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b: begin
                    exp_aluop  = {2'b00, fn};
                    exp_alusel = 3'd4;
                end
                6'h00, 6'h04: begin
                    exp_aluop  = 8'h7c;
                    exp_alusel = 3'd2;
                end
                6'h02, 6'h06: begin
                    exp_aluop  = 8'h02;
                    exp_alusel = 3'd2;
                end
                6'h03, 6'h07: begin
                    exp_aluop  = 8'h03;
                    exp_alusel = 3'd2;
                end
                6'h0a, 6'h0b: begin
                    exp_aluop  = {2'b00, fn};
                    exp_alusel = 3'd3;
                    exp_movn   = (fn == 6'h0b);
                    exp_movz   = (fn == 6'h0a);
                end
                default: begin
                end
            endcase
            if (exp_alusel != 3'd0) begin
                exp_rd2 = 1'b1;
                exp_rd1 = !(exp_alusel == 3'd2 && fn[2] == 1'b0);    // fixed shifts skip rs
                exp_wraw = (exp_alusel != 3'd3);
                if (!exp_rd1) begin
                    exp_imm = {27'h0, inst[10:6]};
                end
            end
        end else if (op >= 6'h08 && op <= 6'h0f) begin
            exp_wraw = 1'b1;
            exp_rd1  = 1'b1;
            exp_wd   = inst[20:16];
            case (op)
                6'h0c: exp_aluop = 8'h24;
                6'h0d, 6'h0f: exp_aluop = 8'h25;    // lui is or
                6'h0e: exp_aluop = 8'h26;
                default: exp_aluop = 8'h55 + {5'h0, op[2:0]};
            endcase
            exp_alusel = op[2] ? 3'd1 : 3'd4;
            if (op == 6'h0f) begin
                exp_imm = {inst[15:0], 16'h0};
            end else if (!op[2]) begin
                exp_imm = {{16{inst[15]}}, inst[15:0]};
            end
        end
    endtask

    function automatic word_t read_model(reg_addr_t a);
        if (a == 0) begin
            return '0;
        end
        if (wb_we_i && wb_waddr_i == a) begin
            return wb_wdata_i;
        end
        return shadow[a];
    endfunction

    function automatic word_t forward_model(logic rd, reg_addr_t a, word_t imm);
        if (rd && ex_wreg_i && ex_wd_i == a) begin
            return ex_wdata_i;
        end
        if (rd && mem_wreg_i && mem_wd_i == a) begin
            return mem_wdata_i;
        end
        if (rd) begin
            return read_model(a);
        end
        return imm;
    endfunction

    task automatic compare(input string name, input word_t got, input word_t exp,
                           input bit is_decode);
        checks_o++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
            if (is_decode) begin
                decode_errors_o++;
            end else begin
                operand_errors_o++;
            end
        end
    endtask

    // inputs change on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst) begin
            exp_aluop  = '0;
            exp_alusel = '0;
            exp_wreg   = 1'b0;
            exp_wd     = '0;
            exp_op1    = '0;
            exp_op2    = '0;
        end else begin
            model_decode(inst_i);
            exp_op1  = forward_model(exp_rd1, inst_i[25:21], exp_imm);
            exp_op2  = forward_model(exp_rd2, inst_i[20:16], exp_imm);
            exp_wreg = exp_wraw | (exp_movn & (|exp_op2)) | (exp_movz & ~(|exp_op2));
        end
        compare("aluop", 32'(aluop_o), 32'(exp_aluop), 1'b1);
        compare("alusel", 32'(alusel_o), 32'(exp_alusel), 1'b1);
        compare("wreg", 32'(wreg_o), 32'(exp_wreg), 1'b1);
        compare("wd", 32'(wd_o), 32'(exp_wd), 1'b1);
        compare("reg1", reg1_o, exp_op1, 1'b0);
        compare("reg2", reg2_o, exp_op2, 1'b0);
        // shadow follows the write that lands on the next edge
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                shadow[i] = '0;
            end
        end else if (wb_we_i && wb_waddr_i != 0) begin
            shadow[wb_waddr_i] = wb_wdata_i;
        end
    end

endmodule

//--- testbench/tb_decode_stage.sv
module tb_decode_stage import decode_pkg::*; ();

    localparam int reset_cycles = 16;
    localparam int num_insts    = 2000;
    localparam int cycle_limit  = reset_cycles + num_insts + 200;

    logic      clk;
    logic      rst;
    word_t     inst_i;
    logic      ex_wreg_i;
    reg_addr_t ex_wd_i;
    word_t     ex_wdata_i;
    logic      mem_wreg_i;
    reg_addr_t mem_wd_i;
    word_t     mem_wdata_i;
    logic      wb_we_i;
    reg_addr_t wb_waddr_i;
    word_t     wb_wdata_i;
    aluop_e    aluop_o;
    alusel_e   alusel_o;
    logic      wreg_o;
    reg_addr_t wd_o;
    word_t     reg1_o;
    word_t     reg2_o;
    int        decode_errors;
    int        operand_errors;
    int        checks;
    int        cycles;
    logic [31:0] lfsr;

    // kept special functs, then kept opcodes
    logic [5:0] functs [18] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h0a, 6'h0b,
                                6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                                6'h2a, 6'h2b};
    logic [5:0] opcodes [8] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

    decode_stage DUT (.*);

    decode_checker u_checker (
        .decode_errors_o  (decode_errors),
        .operand_errors_o (operand_errors),
        .checks_o         (checks),
        .*
    );

    always #20 clk = ~clk;

    // taps at bits 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic draw_reg(output reg_addr_t r);
        logic [31:0] v;
        logic [31:0] wide;
        draw_bits(3, v);
        draw_bits(1, wide);
        if (wide[0]) begin
            draw_bits(5, v);
        end
        r = v[4:0];    // mostly r0..r7 so hits are common
    endtask

    task automatic draw_data(output word_t d);
        logic [31:0] z;
        draw_bits(2, z);
        draw_bits(32, d);
        if (z[1:0] == 2'b00) begin
            d = '0;    // zero values exercise movz
        end
    endtask

    task automatic drive_cycle();
        logic [31:0] sel;
        logic [31:0] v;
        logic [31:0] low;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        word_t       inst;
        draw_bits(4, sel);
        draw_reg(rs);
        draw_reg(rt);
        draw_reg(rd);
        draw_bits(16, low);
        if (sel[3:0] == 4'h0) begin
            draw_bits(32, inst);
        end else begin
            draw_bits(5, v);
            if (v < 18) begin
                inst = {6'h00, rs, rt, rd, low[4:0], functs[v]};
            end else if (v < 26) begin
                inst = {opcodes[v - 18], rs, rt, low[15:0]};
            end else begin
                inst = '0;
            end
        end
        inst_i <= inst;
        draw_bits(1, v);
        ex_wreg_i <= v[0];
        draw_reg(rd);
        ex_wd_i <= rd;
        draw_data(v);
        ex_wdata_i <= v;
        draw_bits(1, v);
        mem_wreg_i <= v[0];
        draw_reg(rd);
        mem_wd_i <= rd;
        draw_data(v);
        mem_wdata_i <= v;
        draw_bits(1, v);
        wb_we_i <= v[0];
        draw_reg(rd);
        wb_waddr_i <= rd;
        draw_data(v);
        wb_wdata_i <= v;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run hung: cycle limit %0d reached", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        lfsr        = 32'hb219;
        cycles      = 0;
        clk         = 1'b0;
        rst         = 1'b1;
        inst_i      = '0;
        ex_wreg_i   = 1'b0;
        ex_wd_i     = '0;
        ex_wdata_i  = '0;
        mem_wreg_i  = 1'b0;
        mem_wd_i    = '0;
        mem_wdata_i = '0;
        wb_we_i     = 1'b0;
        wb_waddr_i  = '0;
        wb_wdata_i  = '0;
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clk);
            drive_cycle();
        end
        rst <= 1'b0;
        for (int i = 0; i < num_insts; i++) begin
            @(posedge clk);
            drive_cycle();
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, decode errors %0d, operand errors %0d",
                 checks, decode_errors, operand_errors);
        if (decode_errors == 0 && operand_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/decode_pkg.sv
rtl/inst_decoder.sv
rtl/imm_gen.sv
rtl/operand_fwd.sv
rtl/reg_file.sv
rtl/decode_stage.sv
testbench/decode_checker.sv
testbench/tb_decode_stage.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_decode_stage
FILELIST  = list.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
